// ==== cluster_cfg_pkg.sv ====
// Address map, register indices and event numbering shared by the peripheral RTL, imported by each block
package cluster_cfg_pkg;

  // ****************************************
  // Bus address layout
  // ****************************************

  // Address bits 11:10 select the block, bits 5:2 the register
  localparam int unsigned ADDR_W    = 12;
  localparam int unsigned REG_IDX_W = 4;

  localparam logic [1:0] BLK_CTRL  = 2'd0;
  localparam logic [1:0] BLK_TIMER = 2'd1;
  localparam logic [1:0] BLK_EU    = 2'd2;
  // Code 2'd3 has no block behind it

  // Control unit registers
  localparam logic [REG_IDX_W-1:0] REG_EOC       = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_FETCH_EN  = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_BOOT_ADDR = 4'd2;

  // Timer registers
  localparam logic [REG_IDX_W-1:0] REG_TMR_CFG = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_TMR_CNT = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_TMR_CMP = 4'd2;

  // Event unit registers
  localparam logic [REG_IDX_W-1:0] REG_EU_MASK_SET = 4'd0;
  localparam logic [REG_IDX_W-1:0] REG_EU_BUF_CLR  = 4'd1;
  localparam logic [REG_IDX_W-1:0] REG_EU_MASK_RD  = 4'd2;
  localparam logic [REG_IDX_W-1:0] REG_EU_BUF_RD   = 4'd3;

  // ****************************************
  // Events and sizes
  // ****************************************

  localparam int unsigned NB_EVENTS = 3;
  localparam int unsigned EVT_TIMER = 0;
  localparam int unsigned EVT_MBOX  = 1;
  localparam int unsigned EVT_DMA   = 2;

  localparam int unsigned CORE_ID_W = 4;

  // Returned for any access outside the three blocks
  localparam logic [31:0] ERR_RDATA = 32'hDEADB33F;

  // One-hot block select, ctrl in bit 0
  typedef struct packed {
    logic eu;
    logic timer;
    logic ctrl;
  } blk_sel_t;

endpackage

// ==== periph_bus_pkg.sv ====
// Bus request and response structs plus the decoded block request, imported by the bus-facing RTL
package periph_bus_pkg;

  import cluster_cfg_pkg::*;

  // ****************************************
  // External register bus
  // ****************************************

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } periph_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } periph_rsp_t;

  // ****************************************
  // Write data views
  // ****************************************

  // Timer configuration, enable in bit 0
  typedef struct packed {
    logic [28:0] rsvd;
    logic        auto_rst;
    logic        clear;
    logic        enable;
  } timer_cfg_t;

  // Event unit command, event bits at the bottom then the target core
  typedef struct packed {
    logic [24:0]          rsvd;
    logic [CORE_ID_W-1:0] core_id;
    logic [NB_EVENTS-1:0] evt;
  } eu_cmd_t;

  typedef union packed {
    logic [31:0] raw;
    timer_cfg_t  tmr_cfg;
    eu_cmd_t     eu_cmd;
  } wdata_u;

  // Request as seen by the peripherals, one cycle after the bus strobe
  typedef struct packed {
    blk_sel_t             strobe;
    logic                 unmapped;
    logic [REG_IDX_W-1:0] reg_idx;
    logic                 we;
    wdata_u               wdata;
  } blk_req_t;

endpackage

// ==== periph_req_decode.sv ====
// Input stage: registers each bus request and turns its address into a block strobe and register index
`timescale 1ns/100ps

module periph_req_decode (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_i,
  input  periph_bus_pkg::periph_req_t req_data_i,
  output periph_bus_pkg::blk_req_t    blk_req_o
);

  import cluster_cfg_pkg::*;
  import periph_bus_pkg::*;

  logic [1:0]           blk_code;
  blk_sel_t             strobe_d;
  blk_sel_t             strobe_q;
  logic                 unmapped_d;
  logic                 unmapped_q;
  logic [REG_IDX_W-1:0] reg_idx_q;
  logic                 we_q;
  wdata_u               wdata_q;

  assign blk_code = req_data_i.addr[ADDR_W-1 -: 2];

  // Block select, all zero when idle
  always_comb begin
    strobe_d   = '0;
    unmapped_d = 1'b0;
    if (req_i) begin
      case (blk_code)
        BLK_CTRL:  strobe_d.ctrl  = 1'b1;
        BLK_TIMER: strobe_d.timer = 1'b1;
        BLK_EU:    strobe_d.eu    = 1'b1;
        default:   unmapped_d     = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      strobe_q   <= '0;
      unmapped_q <= 1'b0;
    end else begin
      strobe_q   <= strobe_d;
      unmapped_q <= unmapped_d;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      reg_idx_q   <= req_data_i.addr[REG_IDX_W+1:2];
      we_q        <= req_data_i.we;
      wdata_q.raw <= req_data_i.wdata;
    end
  end

  always_comb begin
    blk_req_o.strobe   = strobe_q;
    blk_req_o.unmapped = unmapped_q;
    blk_req_o.reg_idx  = reg_idx_q;
    blk_req_o.we       = we_q;
    blk_req_o.wdata    = wdata_q;
  end

endmodule

// ==== cluster_ctrl_unit.sv ====
// Cluster control registers: end of computation, per-core fetch enable and boot address
`timescale 1ns/100ps

module cluster_ctrl_unit #(
  parameter int unsigned NB_CORES      = 8,
  parameter logic [31:0] BOOT_ADDR     = 32'h1C000000,
  parameter logic [31:0] ROM_BOOT_ADDR = 32'h1A000000
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  periph_bus_pkg::blk_req_t blk_req_i,
  input  logic                     en_sa_boot_i,
  output logic [31:0]              rdata_o,
  output logic                     eoc_o,
  output logic [NB_CORES-1:0]      fetch_enable_o,
  output logic [31:0]              boot_addr_o
);

  import cluster_cfg_pkg::*;

  logic                eoc_q;
  logic [NB_CORES-1:0] fetch_en_q;
  logic [31:0]         boot_addr_q;
  logic                wr_en;

  assign wr_en = blk_req_i.strobe.ctrl && blk_req_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      // Standalone boot starts from ROM
      boot_addr_q <= en_sa_boot_i ? ROM_BOOT_ADDR : BOOT_ADDR;
    end else if (wr_en) begin
      case (blk_req_i.reg_idx)
        REG_EOC:       eoc_q       <= blk_req_i.wdata.raw[0];
        REG_FETCH_EN:  fetch_en_q  <= blk_req_i.wdata.raw[NB_CORES-1:0];
        REG_BOOT_ADDR: boot_addr_q <= blk_req_i.wdata.raw;
        default: ;
      endcase
    end
  end

  // Read back of the current register contents
  always_comb begin
    case (blk_req_i.reg_idx)
      REG_EOC:       rdata_o = {31'b0, eoc_q};
      REG_FETCH_EN:  rdata_o = 32'(fetch_en_q);
      REG_BOOT_ADDR: rdata_o = boot_addr_q;
      default:       rdata_o = '0;
    endcase
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

// ==== cluster_timer.sv ====
// Cluster timer: 32-bit counter with compare match event and optional auto-reset, set up over the bus
`timescale 1ns/100ps

module cluster_timer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  periph_bus_pkg::blk_req_t blk_req_i,
  output logic [31:0]              rdata_o,
  output logic                     timer_evt_o
);

  import cluster_cfg_pkg::*;
  import periph_bus_pkg::*;

  logic        enable_q;
  logic        auto_rst_q;
  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic        match;
  logic        wr_en;
  timer_cfg_t  cfg_rd;

  assign wr_en = blk_req_i.strobe.timer && blk_req_i.we;

  // Match only counts while running
  assign match       = enable_q && (count_q == cmp_q);
  assign timer_evt_o = match;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q   <= 1'b0;
      auto_rst_q <= 1'b0;
      count_q    <= '0;
      cmp_q      <= '0;
    end else begin
      if (enable_q) begin
        if (match && auto_rst_q) begin
          count_q <= '0;
        end else begin
          count_q <= count_q + 32'd1;
        end
      end
      // Bus writes override the counting step
      if (wr_en) begin
        case (blk_req_i.reg_idx)
          REG_TMR_CFG: begin
            enable_q   <= blk_req_i.wdata.tmr_cfg.enable;
            auto_rst_q <= blk_req_i.wdata.tmr_cfg.auto_rst;
            if (blk_req_i.wdata.tmr_cfg.clear) begin
              count_q <= '0;
            end
          end
          REG_TMR_CNT: count_q <= blk_req_i.wdata.raw;
          REG_TMR_CMP: cmp_q   <= blk_req_i.wdata.raw;
          default: ;
        endcase
      end
    end
  end

  // Clear is a one-shot and always reads 0
  always_comb begin
    cfg_rd          = '0;
    cfg_rd.enable   = enable_q;
    cfg_rd.auto_rst = auto_rst_q;
    case (blk_req_i.reg_idx)
      REG_TMR_CFG: rdata_o = cfg_rd;
      REG_TMR_CNT: rdata_o = count_q;
      REG_TMR_CMP: rdata_o = cmp_q;
      default:     rdata_o = '0;
    endcase
  end

endmodule

// ==== event_unit.sv ====
// Event unit: per-core event buffers and masks fed by timer, mailbox and DMA, driving core interrupt requests
`timescale 1ns/100ps

module event_unit #(
  parameter int unsigned NB_CORES = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  periph_bus_pkg::blk_req_t blk_req_i,
  input  logic                     timer_evt_i,
  input  logic                     mbox_evt_i,
  input  logic [NB_CORES-1:0]      dma_evt_i,
  output logic [31:0]              rdata_o,
  output logic [NB_CORES-1:0]      irq_req_o
);

  import cluster_cfg_pkg::*;

  logic [NB_CORES-1:0][NB_EVENTS-1:0] buf_q;
  logic [NB_CORES-1:0][NB_EVENTS-1:0] mask_q;
  logic [NB_CORES-1:0][NB_EVENTS-1:0] evt_in;
  logic [NB_CORES-1:0][NB_EVENTS-1:0] clr_bits;
  logic [NB_CORES-1:0]                core_sel;
  logic                               wr_mask;
  logic                               wr_clr;

  assign wr_mask = blk_req_i.strobe.eu && blk_req_i.we &&
                   (blk_req_i.reg_idx == REG_EU_MASK_SET);
  assign wr_clr  = blk_req_i.strobe.eu && blk_req_i.we &&
                   (blk_req_i.reg_idx == REG_EU_BUF_CLR);

  // ****************************************
  // Per-core event routing
  // ****************************************

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      // A core id beyond NB_CORES selects nobody
      core_sel[c] = (blk_req_i.wdata.eu_cmd.core_id == CORE_ID_W'(c));

      evt_in[c]            = '0;
      evt_in[c][EVT_TIMER] = timer_evt_i;
      evt_in[c][EVT_MBOX]  = mbox_evt_i;
      evt_in[c][EVT_DMA]   = dma_evt_i[c];

      clr_bits[c] = (wr_clr && core_sel[c]) ? blk_req_i.wdata.eu_cmd.evt : '0;

      irq_req_o[c] = |(buf_q[c] & mask_q[c]);
    end
  end

  // ****************************************
  // Buffers and masks
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_q  <= '0;
      mask_q <= '0;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        // Set after clear so an incoming event is never lost
        buf_q[c] <= (buf_q[c] & ~clr_bits[c]) | evt_in[c];
        if (wr_mask && core_sel[c]) begin
          mask_q[c] <= blk_req_i.wdata.eu_cmd.evt;
        end
      end
    end
  end

  // All cores side by side, core c at bit 3c
  always_comb begin
    case (blk_req_i.reg_idx)
      REG_EU_MASK_RD: rdata_o = 32'(mask_q);
      REG_EU_BUF_RD:  rdata_o = 32'(buf_q);
      default:        rdata_o = '0;
    endcase
  end

endmodule

// ==== periph_resp_mux.sv ====
// Output stage: picks the addressed block's read data and registers the bus response
`timescale 1ns/100ps

module periph_resp_mux (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  periph_bus_pkg::blk_req_t    blk_req_i,
  input  logic [31:0]                 ctrl_rdata_i,
  input  logic [31:0]                 timer_rdata_i,
  input  logic [31:0]                 eu_rdata_i,
  output logic                        r_valid_o,
  output periph_bus_pkg::periph_rsp_t rsp_o
);

  import cluster_cfg_pkg::*;

  logic        valid_d;
  logic        r_valid_q;
  logic [31:0] sel_rdata;

  assign valid_d = (blk_req_i.strobe != '0) || blk_req_i.unmapped;

  always_comb begin
    if (blk_req_i.strobe.ctrl) begin
      sel_rdata = ctrl_rdata_i;
    end else if (blk_req_i.strobe.timer) begin
      sel_rdata = timer_rdata_i;
    end else if (blk_req_i.strobe.eu) begin
      sel_rdata = eu_rdata_i;
    end else begin
      sel_rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= valid_d;
    end
  end

  // Writes answer with 0, unmapped accesses with the error word
  always_ff @(posedge clk_i) begin
    if (valid_d) begin
      rsp_o.err   <= blk_req_i.unmapped;
      rsp_o.rdata <= blk_req_i.unmapped ? ERR_RDATA :
                     blk_req_i.we       ? 32'b0     : sel_rdata;
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

// ==== cluster_periph_top.sv ====
// Cluster peripheral top: connects the request decoder, the three peripherals and the response mux
`timescale 1ns/100ps

module cluster_periph_top #(
  parameter int unsigned NB_CORES      = 8,
  parameter logic [31:0] BOOT_ADDR     = 32'h1C000000,
  parameter logic [31:0] ROM_BOOT_ADDR = 32'h1A000000
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_i,
  input  periph_bus_pkg::periph_req_t req_data_i,
  input  logic                        en_sa_boot_i,
  input  logic                        mbox_evt_i,
  input  logic [NB_CORES-1:0]         dma_evt_i,
  output logic                        r_valid_o,
  output periph_bus_pkg::periph_rsp_t rsp_o,
  output logic                        eoc_o,
  output logic [NB_CORES-1:0]         fetch_enable_o,
  output logic [31:0]                 boot_addr_o,
  output logic [NB_CORES-1:0]         irq_req_o
);

  import periph_bus_pkg::*;

  blk_req_t    blk_req;
  logic [31:0] ctrl_rdata;
  logic [31:0] timer_rdata;
  logic [31:0] eu_rdata;
  logic        timer_evt;

  // ****************************************
  // Request side
  // ****************************************

  periph_req_decode u_req_decode (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .req_i      ( req_i      ),
    .req_data_i ( req_data_i ),
    .blk_req_o  ( blk_req    )
  );

  // ****************************************
  // Peripherals
  // ****************************************

  cluster_ctrl_unit #(
    .NB_CORES      ( NB_CORES      ),
    .BOOT_ADDR     ( BOOT_ADDR     ),
    .ROM_BOOT_ADDR ( ROM_BOOT_ADDR )
  ) u_ctrl_unit (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .blk_req_i      ( blk_req        ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer u_timer (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .blk_req_i   ( blk_req     ),
    .rdata_o     ( timer_rdata ),
    .timer_evt_o ( timer_evt   )
  );

  event_unit #(
    .NB_CORES ( NB_CORES )
  ) u_event_unit (
    .clk_i       ( clk_i      ),
    .rst_i       ( rst_i      ),
    .blk_req_i   ( blk_req    ),
    .timer_evt_i ( timer_evt  ),
    .mbox_evt_i  ( mbox_evt_i ),
    .dma_evt_i   ( dma_evt_i  ),
    .rdata_o     ( eu_rdata   ),
    .irq_req_o   ( irq_req_o  )
  );

  // ****************************************
  // Response side
  // ****************************************

  periph_resp_mux u_resp_mux (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .blk_req_i     ( blk_req     ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .eu_rdata_i    ( eu_rdata    ),
    .r_valid_o     ( r_valid_o   ),
    .rsp_o         ( rsp_o       )
  );

endmodule

// ==== cluster_periph_chk.sv ====
// Bus timing and reset assertions, bound onto the peripheral top level in simulation
`timescale 1ns/100ps

module cluster_periph_chk #(
  parameter int unsigned NB_CORES = 8
) (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        req_i,
  input logic                        r_valid_o,
  input periph_bus_pkg::periph_rsp_t rsp_o,
  input logic [NB_CORES-1:0]         irq_req_o
);

  import cluster_cfg_pkg::*;

  // Every response belongs to a strobe two cycles back
  a_latency: assert property (@(posedge clk_i) disable iff (rst_i) r_valid_o |-> $past(req_i, 2))
    else $error("Response valid without a request two cycles earlier");

  a_reset: assert property (@(posedge clk_i) (rst_i && $past(rst_i)) |-> (!r_valid_o && irq_req_o == '0))
    else $error("Outputs active during reset");

  a_err_data: assert property (@(posedge clk_i) (r_valid_o && rsp_o.err) |-> rsp_o.rdata == ERR_RDATA)
    else $error("Error response without the error word");

endmodule

bind cluster_periph_top cluster_periph_chk #(
  .NB_CORES ( NB_CORES )
) u_chk (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .req_i     ( req_i     ),
  .r_valid_o ( r_valid_o ),
  .rsp_o     ( rsp_o     ),
  .irq_req_o ( irq_req_o )
);

// ==== tb_cluster_periph.sv ====
// Testbench for the cluster peripheral block: seeded random bus traffic checked against a cycle model
`timescale 1ns/100ps

module tb_cluster_periph;

  import cluster_cfg_pkg::*;
  import periph_bus_pkg::*;

  localparam int unsigned NB           = 8;
  localparam logic [31:0] EXP_BOOT     = 32'h1C000000;
  // Tests take about 2000 cycles, limit leaves more than twice that
  localparam int unsigned MAX_CYCLES   = 5000;

  logic              clk_i;
  logic              rst_i;
  logic              req_i;
  periph_req_t       req_data_i;
  logic              en_sa_boot_i;
  logic              mbox_evt_i;
  logic [NB-1:0]     dma_evt_i;
  logic              r_valid_o;
  periph_rsp_t       rsp_o;
  logic              eoc_o;
  logic [NB-1:0]     fetch_enable_o;
  logic [31:0]       boot_addr_o;
  logic [NB-1:0]     irq_req_o;

  integer            seed;
  int unsigned       cycles;
  int unsigned       errors;
  int unsigned       checks;
  int unsigned       tests_run;
  int unsigned       issued;
  int unsigned       answered;
  logic              next_mbox;
  logic [NB-1:0]     next_dma;

  // Reference model state
  logic [32:0]       exp_q[$];
  logic              exp_valid;
  logic              s1_valid;
  logic              s1_we;
  logic [1:0]        s1_blk;
  logic [3:0]        s1_idx;
  logic [31:0]       s1_data;
  logic              m_eoc;
  logic [NB-1:0]     m_fetch;
  logic [31:0]       m_boot;
  logic              m_en;
  logic              m_auto;
  logic [31:0]       m_cnt;
  logic [31:0]       m_cmp;
  logic [2:0]        m_buf [NB];
  logic [2:0]        m_mask [NB];

  cluster_periph_top u_cluster_periph_top (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .req_i          ( req_i          ),
    .req_data_i     ( req_data_i     ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .mbox_evt_i     ( mbox_evt_i     ),
    .dma_evt_i      ( dma_evt_i      ),
    .r_valid_o      ( r_valid_o      ),
    .rsp_o          ( rsp_o          ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .irq_req_o      ( irq_req_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ****************************************
  // Reference model, one step per edge
  // ****************************************

  function automatic logic [31:0] model_rdata(input logic [1:0] blk, input logic [3:0] idx);
    logic [31:0] packed_bits;
    packed_bits = '0;
    if (blk == BLK_CTRL) begin
      if (idx == REG_EOC) return {31'b0, m_eoc};
      if (idx == REG_FETCH_EN) return 32'(m_fetch);
      if (idx == REG_BOOT_ADDR) return m_boot;
    end else if (blk == BLK_TIMER) begin
      if (idx == REG_TMR_CFG) return {29'b0, m_auto, 1'b0, m_en};
      if (idx == REG_TMR_CNT) return m_cnt;
      if (idx == REG_TMR_CMP) return m_cmp;
    end else if (idx == REG_EU_MASK_RD || idx == REG_EU_BUF_RD) begin
      for (int c = 0; c < NB; c++) begin
        packed_bits[3*c +: 3] = (idx == REG_EU_MASK_RD) ? m_mask[c] : m_buf[c];
      end
      return packed_bits;
    end
    return 32'b0;
  endfunction

  always @(posedge clk_i) begin
    logic       t_evt;
    logic [2:0] clr;
    logic       eu_wr;
    if (rst_i) begin
      exp_valid = 1'b0;
      s1_valid  = 1'b0;
      m_eoc     = 1'b0;
      m_fetch   = '0;
      m_boot    = EXP_BOOT;
      m_en      = 1'b0;
      m_auto    = 1'b0;
      m_cnt     = '0;
      m_cmp     = '0;
      for (int c = 0; c < NB; c++) begin
        m_buf[c]  = '0;
        m_mask[c] = '0;
      end
    end else begin
      exp_valid = s1_valid;
      if (s1_valid) begin
        if (s1_blk == 2'd3) exp_q.push_back({ERR_RDATA, 1'b1});
        else if (s1_we) exp_q.push_back(33'b0);
        else exp_q.push_back({model_rdata(s1_blk, s1_idx), 1'b0});
      end
      t_evt = m_en && (m_cnt == m_cmp);
      if (m_en) m_cnt = (t_evt && m_auto) ? 32'b0 : m_cnt + 32'd1;
      eu_wr = s1_valid && s1_we && (s1_blk == BLK_EU);
      for (int c = 0; c < NB; c++) begin
        clr = '0;
        if (eu_wr && s1_idx == REG_EU_BUF_CLR && s1_data[6:3] == 4'(c)) clr = s1_data[2:0];
        // Set wins over clear
        m_buf[c] = (m_buf[c] & ~clr) | {dma_evt_i[c], mbox_evt_i, t_evt};
        if (eu_wr && s1_idx == REG_EU_MASK_SET && s1_data[6:3] == 4'(c)) m_mask[c] = s1_data[2:0];
      end
      if (s1_valid && s1_we && s1_blk == BLK_CTRL) begin
        if (s1_idx == REG_EOC) m_eoc = s1_data[0];
        if (s1_idx == REG_FETCH_EN) m_fetch = s1_data[NB-1:0];
        if (s1_idx == REG_BOOT_ADDR) m_boot = s1_data;
      end
      if (s1_valid && s1_we && s1_blk == BLK_TIMER) begin
        if (s1_idx == REG_TMR_CFG) begin
          m_en   = s1_data[0];
          m_auto = s1_data[2];
          if (s1_data[1]) m_cnt = '0;
        end
        if (s1_idx == REG_TMR_CNT) m_cnt = s1_data;
        if (s1_idx == REG_TMR_CMP) m_cmp = s1_data;
      end
      s1_valid = req_i;
      s1_we    = req_data_i.we;
      s1_blk   = req_data_i.addr[11:10];
      s1_idx   = req_data_i.addr[5:2];
      s1_data  = req_data_i.wdata;
    end
  end

  // ****************************************
  // Checks at the falling edge
  // ****************************************

  task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  always @(negedge clk_i) begin
    logic [32:0] exp_rsp;
    logic [NB-1:0] exp_irq;
    if (!rst_i) begin
      check32("r_valid_o", 32'(exp_valid), 32'(r_valid_o));
      if (exp_valid) begin
        if (exp_q.size() == 0) begin
          $display("Model has no expected response for this cycle");
          errors++;
        end else begin
          exp_rsp = exp_q.pop_front();
          check32("rsp_o.rdata", exp_rsp[32:1], rsp_o.rdata);
          check32("rsp_o.err", 32'(exp_rsp[0]), 32'(rsp_o.err));
          answered++;
        end
      end
      for (int c = 0; c < NB; c++) exp_irq[c] = |(m_buf[c] & m_mask[c]);
      check32("irq_req_o", 32'(exp_irq), 32'(irq_req_o));
      check32("eoc_o", 32'(m_eoc), 32'(eoc_o));
      check32("fetch_enable_o", 32'(m_fetch), 32'(fetch_enable_o));
      check32("boot_addr_o", m_boot, boot_addr_o);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, responses still missing", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ****************************************
  // Stimulus
  // ****************************************

  task automatic send(input logic we, input logic [1:0] blk, input logic [3:0] idx,
                      input logic [31:0] data);
    @(posedge clk_i);
    #2;
    req_i            = 1'b1;
    req_data_i.we    = we;
    req_data_i.addr  = {blk, 4'b0, idx, 2'b0};
    req_data_i.wdata = data;
    mbox_evt_i       = next_mbox;
    dma_evt_i        = next_dma;
    issued++;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #2;
    req_i      = 1'b0;
    mbox_evt_i = next_mbox;
    dma_evt_i  = next_dma;
  endtask

  task automatic drain();
    next_mbox = 1'b0;
    next_dma  = '0;
    idle();
    while (answered != issued) idle();
  endtask

  task automatic test_done(input string name, input int unsigned err_start);
    tests_run++;
    $display("Test %s done, %0d errors", name, errors - err_start);
  endtask

  initial begin
    int unsigned e0;
    logic [31:0] r;
    logic [1:0]  blk;
    seed = 67;
    cycles = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    issued = 0;
    answered = 0;
    next_mbox = 1'b0;
    next_dma = '0;
    rst_i = 1'b1;
    req_i = 1'b0;
    req_data_i = '0;
    en_sa_boot_i = 1'b0;
    mbox_evt_i = 1'b0;
    dma_evt_i = '0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    e0 = errors;
    check32("boot_addr_o", EXP_BOOT, boot_addr_o);
    for (int i = 0; i < 3; i++) send(1'b0, BLK_CTRL, 4'(i), 32'b0);
    for (int i = 0; i < 3; i++) send(1'b0, BLK_TIMER, 4'(i), 32'b0);
    send(1'b0, BLK_EU, REG_EU_MASK_RD, 32'b0);
    send(1'b0, BLK_EU, REG_EU_BUF_RD, 32'b0);
    drain();
    test_done("reset_values", e0);

    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      send(r[0], r[2:1], {2'b0, r[4:3]}, $random(seed));
    end
    drain();
    test_done("response_timing", e0);

    e0 = errors;
    for (int i = 0; i < 100; i++) begin
      r = $random(seed);
      send(1'b1, BLK_CTRL, {2'b0, r[1:0]}, $random(seed));
      send(1'b0, BLK_CTRL, {2'b0, r[1:0]}, 32'b0);
    end
    drain();
    test_done("control_regs", e0);

    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      send(1'b1, BLK_TIMER, REG_TMR_CMP, 32'd10 + 32'(r[4:0]));
      send(1'b1, BLK_TIMER, REG_TMR_CFG, 32'h6);
      // Empty the timer bit of every core so only this run can set it
      for (int c = 0; c < NB; c++) begin
        send(1'b1, BLK_EU, REG_EU_BUF_CLR, {25'b0, 4'(c), 3'b001});
      end
      send(1'b1, BLK_TIMER, REG_TMR_CFG, r[8] ? 32'h5 : 32'h1);
      repeat (20 + r[15:9]) idle();
      send(1'b1, BLK_TIMER, REG_TMR_CFG, 32'h0);
      send(1'b0, BLK_TIMER, REG_TMR_CNT, 32'b0);
      send(1'b0, BLK_EU, REG_EU_BUF_RD, 32'b0);
      send(1'b1, BLK_TIMER, REG_TMR_CFG, 32'h2);
      send(1'b0, BLK_TIMER, REG_TMR_CNT, 32'b0);
      drain();
    end
    test_done("timer", e0);

    e0 = errors;
    for (int i = 0; i < 600; i++) begin
      r = $random(seed);
      next_mbox = (r[3:0] == 4'd0);
      next_dma  = NB'($random(seed) & $random(seed) & $random(seed));
      blk = r[5:4];
      if (blk == 2'd0) send(1'b1, BLK_EU, REG_EU_MASK_SET, {25'b0, r[12:6]});
      else if (blk == 2'd1) send(1'b1, BLK_EU, REG_EU_BUF_CLR, {25'b0, r[12:6]});
      else if (blk == 2'd2) send(1'b0, BLK_EU, r[13] ? REG_EU_BUF_RD : REG_EU_MASK_RD, 32'b0);
      else idle();
    end
    drain();
    test_done("event_unit", e0);

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== list.f ====
cluster_cfg_pkg.sv
periph_bus_pkg.sv
periph_req_decode.sv
cluster_ctrl_unit.sv
cluster_timer.sv
event_unit.sv
periph_resp_mux.sv
cluster_periph_top.sv
cluster_periph_chk.sv
tb_cluster_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_cluster_periph -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -qF "*** FAILED ***" sim.log; then
  exit 1
fi
if ! grep -qF "*** PASSED ***" sim.log; then
  exit 1
fi
exit 0
